// File: flist.f
src/macBoardPkg.sv
src/romLoader.sv
src/resetStretcher.sv
src/memoryArbiter.sv
src/wordMemory.sv
src/macBoardTop.sv
tb/macBoardTb.sv

// File: runSim.sh
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --top-module macBoardTb -f flist.f -o simMacBoard \
	&& ./obj_dir/simMacBoard > sim.log 2>&1 \
	|| { echo "build or run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log \
	&& echo "run passed" \
	|| { echo "run failed, see sim.log"; exit 1; }

// File: tb/macBoardTb.sv
// clock, reset, spi download driver, random cpu traffic, reference model, checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module macBoardTb import macBoardPkg::*; ();

	localparam int RamAddrBits  = 9;
	localparam int ResetCycles  = 40;
	localparam int ClkPeriod    = 100;
	localparam int SpiHalf      = 4;      // clk8 cycles per spi clock phase
	localparam int RomWords     = 64;
	localparam int DiskWords    = 32;
	localparam int BusyWords    = 8;      // frame used while the cpu keeps running
	localparam int StretchWords = 2;
	localparam int DiskProbes   = 64;
	localparam int RamOps       = 600;
	localparam int BusyOps      = 12;
	localparam int UpperBase    = 1 << (MemAddrBits - 1);
	localparam int HalfWords    = 1 << (MemAddrBits - 1);
	localparam int KindRom      = 0;
	localparam int KindRam      = 1;
	localparam int KindDisk     = 2;

	// --------------------------------------------------
	// run length budget for the watchdog
	// --------------------------------------------------
	localparam int FrameBits   = 4 * 8 + 16 * (RomWords + DiskWords + BusyWords + StretchWords);
	localparam int FrameCycles = FrameBits * 2 * SpiHalf + 16 * SpiHalf;
	localparam int AccessCount = 2 * RomWords + DiskProbes + (1 << RamAddrBits) + RamOps
	                           + 3 * BusyOps + 2 * BusyWords;
	localparam int WatchdogCycles = 2 * (FrameCycles + 3 * AccessCount + 3 * (ResetCycles + 16))
	                              + 64;

	logic                   clk8 = 1'b0;
	logic                   rst;
	logic                   spiSck;
	logic                   spiSs;
	logic                   spiDi;
	logic                   menuReset;
	logic [MemAddrBits-1:0] cpuAddr;
	logic                   romOe;
	logic                   ramOe;
	logic                   ramWe;
	logic                   upperDs;
	logic                   lowerDs;
	logic                   extraRomAck;
	logic [MemWordBits-1:0] cpuWriteData;
	wire  [MemWordBits-1:0] cpuReadData;
	wire                    downloading;
	wire                    cpuReset;

	logic [15:0]            refMem [0:(1 << MemAddrBits) - 1];  // reference copy of the memory
	logic [15:0]            frameWords [0:RomWords-1];          // payload of the next frame
	logic [MemAddrBits-1:0] busyAddr [0:BusyOps-1];
	integer                 seed = 38956;
	int                     errors = 0;
	int                     checks = 0;
	int                     testErrors;
	int                     testChecks;

	macBoardTop #(.RamAddrBits(RamAddrBits), .ResetCycles(ResetCycles)) UUT (
		.clk8(clk8), .rst(rst), .spiSck(spiSck), .spiSs(spiSs), .spiDi(spiDi),
		.menuReset(menuReset), .cpuAddr(cpuAddr), .romOe(romOe), .ramOe(ramOe),
		.ramWe(ramWe), .upperDs(upperDs), .lowerDs(lowerDs), .extraRomAck(extraRomAck),
		.cpuWriteData(cpuWriteData), .cpuReadData(cpuReadData),
		.downloading(downloading), .cpuReset(cpuReset)
	);

	always #(ClkPeriod / 2) clk8 = ~clk8;

	// --------------------------------------------------
	// reference model rules
	// --------------------------------------------------
	function automatic int romIndex(input logic [MemAddrBits-1:0] byteAddr);
		return UpperBase + int'(byteAddr) / 2;
	endfunction

	// offset wraps inside the upper half
	function automatic int diskIndex(input logic [MemAddrBits-1:0] byteAddr);
		return UpperBase + (int'(DiskOffset) + int'(byteAddr) / 2) % HalfWords;
	endfunction

	function automatic int ramIndex(input logic [MemAddrBits-1:0] byteAddr);
		return (int'(byteAddr) / 2) % (1 << RamAddrBits);  // aliased into the lower half
	endfunction

	function automatic logic [15:0] mergeBytes(input logic [15:0] old, input logic [15:0] data,
	                                           input logic [1:0] be);
		logic [15:0] merged;
		merged = old;
		if (be[1])
			merged[15:8] = data[15:8];
		if (be[0])
			merged[7:0] = data[7:0];
		return merged;
	endfunction

	// even byte gives the high byte twice and odd the low byte twice
	function automatic logic [15:0] dupByte(input logic [15:0] word, input logic odd);
		return odd ? {word[7:0], word[7:0]} : {word[15:8], word[15:8]};
	endfunction

	function automatic logic [15:0] randomWord();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	task automatic compare(input string name, input logic [15:0] got,
	                       input logic [15:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic startTest();
		testErrors = errors;
		testChecks = checks;
	endtask

	task automatic endTest(input string name);
		$display("test %s: %0d checks, %0d errors", name,
		         checks - testChecks, errors - testErrors);
	endtask

	// --------------------------------------------------
	// spi download driver
	// --------------------------------------------------
	task automatic spiBit(input logic b);
		spiDi  <= b;       // set up while sck is low
		spiSck <= 1'b0;
		repeat (SpiHalf) @(posedge clk8);
		spiSck <= 1'b1;    // loader samples on this edge
		repeat (SpiHalf) @(posedge clk8);
	endtask

	task automatic fillFrame(input int words);
		for (int i = 0; i < words; i++)
			frameWords[i] = randomWord();
	endtask

	task automatic sendFrame(input logic [7:0] index, input int words);
		int offset;
		@(posedge clk8);
		spiSs <= 1'b0;
		repeat (SpiHalf) @(posedge clk8);
		for (int b = 7; b >= 1; b--)
			spiBit(index[b]);
		// last index bit, downloading follows the two flop synchronizer
		spiDi  <= index[0];
		spiSck <= 1'b0;
		repeat (SpiHalf) @(posedge clk8);
		spiSck <= 1'b1;
		repeat (2) @(posedge clk8);
		@(negedge clk8);
		compare("downloading", 16'(downloading), 16'h0000);
		@(posedge clk8);
		@(negedge clk8);
		compare("downloading", 16'(downloading), 16'h0001);  // the cycle after the index byte
		repeat (SpiHalf - 3) @(posedge clk8);
		for (int i = 0; i < words; i++)
			for (int b = 15; b >= 0; b--)
				spiBit(frameWords[i][b]);
		spiSck <= 1'b0;
		repeat (SpiHalf) @(posedge clk8);
		spiSs <= 1'b1;
		repeat (2) @(posedge clk8);
		@(negedge clk8);
		compare("downloading", 16'(downloading), 16'h0001);
		@(posedge clk8);
		@(negedge clk8);
		compare("downloading", 16'(downloading), 16'h0000);  // the cycle after ss is synced
		repeat (2 * SpiHalf - 3) @(posedge clk8);
		// index 0 is the rom base and every other index the disk area
		offset = (index[IndexBits-1:0] == '0) ? 0 : int'(DiskOffset);
		for (int i = 0; i < words; i++)
			refMem[UpperBase + (offset + i) % HalfWords] = frameWords[i];
	endtask

	// --------------------------------------------------
	// cpu bus cycles
	// --------------------------------------------------
	task automatic cpuRead(input int kind, input logic [MemAddrBits-1:0] byteAddr,
	                       output logic [15:0] data);
		@(posedge clk8);
		cpuAddr     <= byteAddr;
		romOe       <= (kind == KindRom);
		ramOe       <= (kind == KindRam);
		extraRomAck <= (kind == KindDisk);
		upperDs     <= 1'b1;
		lowerDs     <= 1'b1;
		@(posedge clk8);
		romOe       <= 1'b0;
		ramOe       <= 1'b0;
		extraRomAck <= 1'b0;
		upperDs     <= 1'b0;
		lowerDs     <= 1'b0;
		@(negedge clk8);   // data valid one cycle after the request
		data = cpuReadData;
	endtask

	task automatic cpuWrite(input logic [MemAddrBits-1:0] byteAddr, input logic [15:0] data,
	                        input logic [1:0] be);
		@(posedge clk8);
		cpuAddr      <= byteAddr;
		cpuWriteData <= data;
		ramWe        <= 1'b1;
		upperDs      <= be[1];
		lowerDs      <= be[0];
		@(posedge clk8);
		ramWe   <= 1'b0;
		upperDs <= 1'b0;
		lowerDs <= 1'b0;
	endtask

	// counts cycles of cpuReset after the last source has dropped
	task automatic measureStretch();
		int   held;
		logic source;
		source = 1'b1;
		while (source) begin
			@(negedge clk8);
			source = rst | downloading | menuReset;
			if (source && !cpuReset) begin
				errors++;
				$display("cpuReset went low while a reset source was still active");
			end
		end
		held = 0;
		while (cpuReset && held <= ResetCycles + 4) begin
			held++;
			@(negedge clk8);
		end
		compare("cpuReset hold cycles", held[15:0], 16'(ResetCycles));
	endtask

	// --------------------------------------------------
	// watchdog
	// --------------------------------------------------
	initial begin
		repeat (WatchdogCycles) @(posedge clk8);
		$display("timeout: the run did not finish within %0d clock cycles", WatchdogCycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		logic [15:0]            data;
		logic [15:0]            r16;
		logic [15:0]            sel;
		logic [MemAddrBits-1:0] addr;
		rst          = 1'b1;
		spiSck       = 1'b0;
		spiSs        = 1'b1;   // no frame
		spiDi        = 1'b0;
		menuReset    = 1'b0;
		cpuAddr      = '0;
		romOe        = 1'b0;
		ramOe        = 1'b0;
		ramWe        = 1'b0;
		upperDs      = 1'b0;
		lowerDs      = 1'b0;
		extraRomAck  = 1'b0;
		cpuWriteData = '0;
		repeat (3) @(posedge clk8);
		rst <= 1'b0;

		// test 1 loads the os rom and reads back every word
		startTest();
		fillFrame(RomWords);
		sendFrame(8'd0, RomWords);
		for (int i = 0; i < RomWords; i++) begin
			cpuRead(KindRom, 12'(2 * i), data);
			compare("cpuReadData rom", data, refMem[romIndex(12'(2 * i))]);
		end
		endTest("1 rom download");

		// test 2 loads the disk image and reads bytes and the rom again
		startTest();
		fillFrame(DiskWords);
		sendFrame(8'd1, DiskWords);
		for (int i = 0; i < DiskProbes; i++) begin
			r16  = randomWord();
			addr = {6'd0, r16[5:0]};   // inside the 32 word image
			cpuRead(KindDisk, addr, data);
			compare("cpuReadData disk", data, dupByte(refMem[diskIndex(addr)], addr[0]));
		end
		for (int i = 0; i < RomWords; i++) begin
			cpuRead(KindRom, 12'(2 * i), data);
			compare("cpuReadData rom", data, refMem[romIndex(12'(2 * i))]);
		end
		endTest("2 disk download");

		// test 3 fills the ram first so every word is known
		startTest();
		for (int w = 0; w < (1 << RamAddrBits); w++) begin
			r16 = randomWord();
			cpuWrite(12'(2 * w), r16, 2'b11);
			refMem[ramIndex(12'(2 * w))] = r16;
		end
		for (int i = 0; i < RamOps; i++) begin
			sel  = randomWord();
			r16  = randomWord();
			addr = r16[MemAddrBits-1:0];   // often past the ram mask
			if (sel[0]) begin
				r16 = randomWord();
				cpuWrite(addr, r16, sel[2:1]);
				refMem[ramIndex(addr)] = mergeBytes(refMem[ramIndex(addr)], r16, sel[2:1]);
			end else begin
				cpuRead(KindRam, addr, data);
				compare("cpuReadData ram", data, refMem[ramIndex(addr)]);
			end
		end
		endTest("3 ram traffic");

		// test 4 locks the cpu out while a frame is loading
		startTest();
		fillFrame(BusyWords);
		fork
			sendFrame(8'd2, BusyWords);
			begin
				while (!downloading)
					@(negedge clk8);
				for (int k = 0; k < BusyOps; k++) begin
					cpuRead(k % 3, 12'(2 * k), data);   // rom then ram then disk in turn
					compare("cpuReadData busy", data, 16'hffff);
					r16 = randomWord();
					busyAddr[k] = r16[MemAddrBits-1:0];
					cpuWrite(busyAddr[k], randomWord(), 2'b11);   // should be dropped
				end
			end
		join
		for (int k = 0; k < BusyOps; k++) begin
			cpuRead(KindRam, busyAddr[k], data);
			compare("cpuReadData ram", data, refMem[ramIndex(busyAddr[k])]);
		end
		for (int i = 0; i < 2 * BusyWords; i++) begin
			cpuRead(KindDisk, 12'(i), data);
			compare("cpuReadData disk", data, dupByte(refMem[diskIndex(12'(i))], i[0]));
		end
		endTest("4 download lockout");

		// test 5 measures the reset stretch after each source
		startTest();
		@(posedge clk8);
		rst <= 1'b1;
		repeat (3) @(posedge clk8);
		rst <= 1'b0;
		measureStretch();
		fillFrame(StretchWords);
		fork
			sendFrame(8'd3, StretchWords);
			begin
				while (!downloading)
					@(negedge clk8);
				measureStretch();
			end
		join
		@(posedge clk8);
		menuReset <= 1'b1;
		repeat (5) @(posedge clk8);
		menuReset <= 1'b0;
		measureStretch();
		endTest("5 reset stretch");

		$display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/macBoardTop.sv
// loader, reset stretcher, arbiter and memory wiring
`timescale 1ns/10ps
`default_nettype none

module macBoardTop import macBoardPkg::*; #(
	parameter int RamAddrBits = 9,
	parameter int ResetCycles = 40
) (
	input  wire                    clk8,
	input  wire                    rst,
	// io controller download link
	input  wire                    spiSck,
	input  wire                    spiSs,
	input  wire                    spiDi,
	input  wire                    menuReset,
	// cpu memory request pins
	input  wire [MemAddrBits-1:0]  cpuAddr,
	input  wire                    romOe,
	input  wire                    ramOe,
	input  wire                    ramWe,
	input  wire                    upperDs,
	input  wire                    lowerDs,
	input  wire                    extraRomAck,
	input  wire [MemWordBits-1:0]  cpuWriteData,
	output wire [MemWordBits-1:0]  cpuReadData,
	// status
	output wire                    downloading,
	output wire                    cpuReset
);
	// --------------------------------------------------
	// loader to arbiter
	// --------------------------------------------------
	wire                    loadWrite;
	wire [IndexBits-1:0]    loadIndex;
	wire [LoadAddrBits-1:0] loadAddr;
	wire [MemWordBits-1:0]  loadData;

	// arbiter to memory
	wire [MemAddrBits-1:0]  memAddr;
	wire [MemWordBits-1:0]  memWriteData;
	wire [1:0]              memByteEn;
	wire                    memWe;
	wire                    memOe;
	wire [MemWordBits-1:0]  memReadData;

	romLoader loader (
		.clk8        (clk8),
		.rst         (rst),
		.spiSck      (spiSck),
		.spiSs       (spiSs),
		.spiDi       (spiDi),
		.downloading (downloading),
		.loadWrite   (loadWrite),
		.loadIndex   (loadIndex),
		.loadAddr    (loadAddr),
		.loadData    (loadData)
	);

	resetStretcher #(.ResetCycles(ResetCycles)) stretcher (
		.clk8        (clk8),
		.rst         (rst),
		.downloading (downloading),
		.menuReset   (menuReset),
		.cpuReset    (cpuReset)
	);

	memoryArbiter #(.RamAddrBits(RamAddrBits)) arbiter (
		.clk8         (clk8),
		.rst          (rst),
		.downloading  (downloading),
		.loadWrite    (loadWrite),
		.loadIndex    (loadIndex),
		.loadAddr     (loadAddr),
		.loadData     (loadData),
		.cpuAddr      (cpuAddr),
		.romOe        (romOe),
		.ramOe        (ramOe),
		.ramWe        (ramWe),
		.upperDs      (upperDs),
		.lowerDs      (lowerDs),
		.extraRomAck  (extraRomAck),
		.cpuWriteData (cpuWriteData),
		.cpuReadData  (cpuReadData),
		.memReadData  (memReadData),
		.memAddr      (memAddr),
		.memWriteData (memWriteData),
		.memByteEn    (memByteEn),
		.memWe        (memWe),
		.memOe        (memOe)
	);

	// stands in for the sdram controller
	wordMemory #(.AddrBits(MemAddrBits)) memory (
		.clk8         (clk8),
		.memAddr      (memAddr),
		.memWriteData (memWriteData),
		.memByteEn    (memByteEn),
		.memWe        (memWe),
		.memOe        (memOe),
		.memReadData  (memReadData)
	);

endmodule

`default_nettype wire

// File: src/wordMemory.sv
// synchronous word ram with byte lanes and registered read
`timescale 1ns/10ps
`default_nettype none

module wordMemory import macBoardPkg::*; #(
	parameter int AddrBits = 12
) (
	input  wire                    clk8,
	input  wire [AddrBits-1:0]     memAddr,
	input  wire [MemWordBits-1:0]  memWriteData,
	input  wire [1:0]              memByteEn,    // lane 1 = upper byte
	input  wire                    memWe,
	input  wire                    memOe,
	output logic [MemWordBits-1:0] memReadData
);
	localparam int Depth = 2 ** AddrBits;

	logic [MemWordBits-1:0] mem [Depth];

	// --------------------------------------------------
	// write per byte lane
	// --------------------------------------------------
	always_ff @(posedge clk8) begin
		if (memWe) begin
			for (int lane = 0; lane < 2; lane++) begin
				if (memByteEn[lane])
					mem[memAddr][lane*8 +: 8] <= memWriteData[lane*8 +: 8];
			end
		end
	end

	// read word valid the cycle after memOe and held otherwise
	always_ff @(posedge clk8) begin
		if (memOe)
			memReadData <= mem[memAddr];
	end

endmodule

`default_nettype wire

// File: src/memoryArbiter.sv
// loader and cpu mux, region mapping and read data shaping
`timescale 1ns/10ps
`default_nettype none

module memoryArbiter import macBoardPkg::*; #(
	parameter int RamAddrBits = 9  // ram aliases every 2^RamAddrBits words
) (
	input  wire                     clk8,
	input  wire                     rst,
	// loader side
	input  wire                     downloading,
	input  wire                     loadWrite,
	input  wire [IndexBits-1:0]     loadIndex,
	input  wire [LoadAddrBits-1:0]  loadAddr,
	input  wire [MemWordBits-1:0]   loadData,
	// cpu side
	input  wire [MemAddrBits-1:0]   cpuAddr,      // byte address
	input  wire                     romOe,
	input  wire                     ramOe,
	input  wire                     ramWe,
	input  wire                     upperDs,
	input  wire                     lowerDs,
	input  wire                     extraRomAck,  // byte read from the disk image
	input  wire [MemWordBits-1:0]   cpuWriteData,
	output logic [MemWordBits-1:0]  cpuReadData,
	// memory side
	input  wire [MemWordBits-1:0]   memReadData,
	output logic [MemAddrBits-1:0]  memAddr,
	output logic [MemWordBits-1:0]  memWriteData,
	output logic [1:0]              memByteEn,    // {upper, lower}
	output logic                    memWe,
	output logic                    memOe
);
	logic [LoadAddrBits-1:0] cpuWord;     // byte address halved
	logic [LoadAddrBits-1:0] ramWord;
	logic [LoadAddrBits-1:0] loadOffset;
	logic [MemAddrBits-1:0]  cpuMemAddr;
	logic [MemWordBits-1:0]  diskByte;
	logic                    downloadDly;
	logic                    extraDly;
	logic                    oddDly;

	// --------------------------------------------------
	// address mapping
	// --------------------------------------------------
	assign cpuWord = cpuAddr[MemAddrBits-1:1];
	assign ramWord = {{(LoadAddrBits - RamAddrBits){1'b0}}, cpuWord[RamAddrBits-1:0]};

	// index 0 is the os rom and anything else goes to the disk area
	assign loadOffset = (loadIndex == '0) ? loadAddr : loadAddr + DiskOffset;

	always_comb begin
		if (extraRomAck)
			cpuMemAddr = {UpperHalf, DiskOffset + cpuWord};
		else if (romOe)
			cpuMemAddr = {UpperHalf, cpuWord};
		else
			cpuMemAddr = {LowerHalf, ramWord};  // masked ram
	end

	// loader owns the memory for the whole download
	assign memAddr      = downloading ? {UpperHalf, loadOffset} : cpuMemAddr;
	assign memWriteData = downloading ? loadData : cpuWriteData;
	assign memByteEn    = downloading ? 2'b11 : {upperDs, lowerDs};
	assign memWe        = downloading ? loadWrite : ramWe;
	assign memOe        = ~downloading & (romOe | ramOe | extraRomAck);

	// --------------------------------------------------
	// read data shaping one cycle behind the request
	// --------------------------------------------------
	always_ff @(posedge clk8) begin
		if (rst) begin
			downloadDly <= 1'b0;
			extraDly    <= 1'b0;
			oddDly      <= 1'b0;
		end else begin
			downloadDly <= downloading;
			extraDly    <= extraRomAck;
			oddDly      <= cpuAddr[0];
		end
	end

	// disk image is byte wide and an odd address takes the low byte
	assign diskByte = oddDly ? {memReadData[7:0], memReadData[7:0]}
	                         : {memReadData[15:8], memReadData[15:8]};

	always_comb begin
		if (downloadDly)
			cpuReadData = '1;  // blank screen during download
		else if (extraDly)
			cpuReadData = diskByte;
		else
			cpuReadData = memReadData;
	end

endmodule

`default_nettype wire

// File: src/resetStretcher.sv
// merges reset sources and extends the cpu reset afterwards
`timescale 1ns/10ps
`default_nettype none

module resetStretcher #(
	parameter int ResetCycles = 40  // extra cycles after the last source drops
) (
	input  wire  clk8,
	input  wire  rst,
	input  wire  downloading,  // rom or disk transfer in progress
	input  wire  menuReset,    // reset entry from the menu
	output logic cpuReset
);
	localparam int CountBits = $clog2(ResetCycles + 1);

	logic [CountBits-1:0] holdCount;
	logic                 anySource;

	assign anySource = rst | downloading | menuReset;

	// reload while any source is active and run down to zero afterwards
	always_ff @(posedge clk8) begin
		if (anySource)
			holdCount <= CountBits'(ResetCycles);
		else if (holdCount != '0)
			holdCount <= holdCount - 1'b1;
	end

	assign cpuReset = anySource | (holdCount != '0);

endmodule

`default_nettype wire

// File: src/romLoader.sv
// spi download receiver producing indexed word writes
`timescale 1ns/10ps
`default_nettype none

module romLoader import macBoardPkg::*; (
	input  wire                     clk8,
	input  wire                     rst,
	input  wire                     spiSck,       // io controller spi clock
	input  wire                     spiSs,        // frame select, active low
	input  wire                     spiDi,        // data from io controller
	output logic                    downloading,  // high from index byte to frame end
	output logic                    loadWrite,    // one pulse per received word
	output logic [IndexBits-1:0]    loadIndex,    // 0 selects the rom and others the disk
	output logic [LoadAddrBits-1:0] loadAddr,     // word offset within the frame
	output logic [MemWordBits-1:0]  loadData
);
	localparam int CountBits = $clog2(WordFrameBits);

	logic [1:0]             sckPipe;   // [1] is the synchronized value
	logic                   sckLast;
	logic [1:0]             ssPipe;
	logic                   ssLast;
	logic [1:0]             diPipe;    // same depth as sck so the bit lines up
	logic [CountBits-1:0]   bitCount;
	logic [MemWordBits-1:0] shiftReg;
	logic [MemWordBits-1:0] nextShift;
	logic                   sckRise;
	logic                   ssFall;
	logic                   ssRise;
	logic                   bitTaken;
	logic                   indexDone;
	logic                   wordDone;

	// --------------------------------------------------
	// pin synchronizers and edge detect
	// --------------------------------------------------
	always_ff @(posedge clk8) begin
		if (rst) begin
			sckPipe <= 2'b00;
			sckLast <= 1'b0;
			ssPipe  <= 2'b11;  // idle deselected
			ssLast  <= 1'b1;
		end else begin
			sckPipe <= {sckPipe[0], spiSck};
			sckLast <= sckPipe[1];
			ssPipe  <= {ssPipe[0], spiSs};
			ssLast  <= ssPipe[1];
		end
	end

	always_ff @(posedge clk8) begin
		diPipe <= {diPipe[0], spiDi};
	end

	assign sckRise = sckPipe[1] & ~sckLast;
	assign ssFall  = ~ssPipe[1] & ssLast;  // frame start
	assign ssRise  = ssPipe[1] & ~ssLast;  // frame end
	assign bitTaken = sckRise & ~ssPipe[1];

	assign nextShift = {shiftReg[MemWordBits-2:0], diPipe[1]};

	// index phase until downloading goes high and word phase after
	assign indexDone = bitTaken & ~downloading & (bitCount == CountBits'(IndexFrameBits - 1));
	assign wordDone  = bitTaken & downloading & (bitCount == CountBits'(WordFrameBits - 1));

	// --------------------------------------------------
	// frame control
	// --------------------------------------------------
	always_ff @(posedge clk8) begin
		if (rst) begin
			bitCount    <= '0;
			downloading <= 1'b0;
			loadWrite   <= 1'b0;
			loadAddr    <= '0;
		end else begin
			loadWrite <= wordDone;  // strobe in the cycle after the last bit
			if (loadWrite)
				loadAddr <= loadAddr + 1'b1;
			if (ssFall) begin
				bitCount <= '0;
				loadAddr <= '0;  // every frame loads from its own base
			end else if (bitTaken) begin
				bitCount <= (indexDone || wordDone) ? '0 : bitCount + 1'b1;
			end
			if (ssRise)
				downloading <= 1'b0;
			else if (indexDone)
				downloading <= 1'b1;
		end
	end

	// shift register and captured payload
	always_ff @(posedge clk8) begin
		if (bitTaken)
			shiftReg <= nextShift;
		if (indexDone)
			loadIndex <= nextShift[IndexBits-1:0];  // upper index bits dropped
		if (wordDone)
			loadData <= nextShift;
	end

endmodule

`default_nettype wire

// File: src/macBoardPkg.sv
// memory map widths, region select constants and spi framing constants
`default_nettype none

package macBoardPkg;

	// --------------------------------------------------
	// memory map
	// --------------------------------------------------
	localparam int MemAddrBits  = 12;  // word address into the shared memory
	localparam int MemWordBits  = 16;  // 68000 data bus width
	localparam int LoadAddrBits = 11;  // offset inside one half of memory

	// top address bit picks the half
	localparam logic UpperHalf = 1'b1;  // os rom and disk image
	localparam logic LowerHalf = 1'b0;  // cpu ram aliased by the arbiter

	// disk image sits behind the rom in the upper half
	localparam logic [LoadAddrBits-1:0] DiskOffset = 11'd1024;

	// --------------------------------------------------
	// spi download framing
	// --------------------------------------------------
	localparam int IndexBits      = 5;   // kept bits of the index byte
	localparam int IndexFrameBits = 8;   // index byte opens every frame
	localparam int WordFrameBits  = 16;  // then one word per 16 bits sent msb first

endpackage

`default_nettype wire
